// File: bench/npc_sva.sv
module npc_sva (
	input logic        clk,
	input logic        rst,
	input logic        arvalid,
	input logic        arready,
	input logic [31:0] araddr,
	input logic        rvalid,
	input logic        rready,
	input logic [1:0]  rresp,
	input logic        commit_valid,
	input logic        halt,
	input logic        bus_error
);
	timeunit 1ns;
	timeprecision 1ps;
	import npc_pkg::*;

	// still waiting for the first address beat out of reset
	logic first_ar;
	// address beat seen since the last commit
	logic ar_seen;

	always @(posedge clk) begin
		if (rst) begin
			first_ar <= 1'b1;
			ar_seen  <= 1'b0;
		end else if (arvalid && arready) begin
			first_ar <= 1'b0;
			ar_seen  <= 1'b1;
		end else if (commit_valid) begin
			ar_seen <= 1'b0;
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> !commit_valid && !halt && !bus_error && !arvalid && !rready)
		else $error("outputs not quiet after reset");

	a_first_addr: assert property (@(posedge clk) disable iff (rst)
		arvalid && arready && first_ar |-> araddr == reset_pc)
		else $error("first fetch not at the reset pc");

	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address dropped or changed before arready");

	a_beat_commit: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready && rresp == axi_okay |-> ##2 commit_valid)
		else $error("good data beat without a commit");

	a_commit_beat: assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> $past(rvalid && rready, 2) && ar_seen)
		else $error("commit without its own fetch");

	a_commit_single: assert property (@(posedge clk) disable iff (rst)
		commit_valid |=> !commit_valid)
		else $error("back to back commits");

	a_halt_idle: assert property (@(posedge clk) disable iff (rst)
		halt |-> !arvalid)
		else $error("read request while halted");

	a_berr_nocommit: assert property (@(posedge clk) disable iff (rst)
		bus_error |-> !commit_valid)
		else $error("commit after a bus error");

endmodule

bind npc_top npc_sva sva_i (.*);

// File: bench/npc_tb.sv
module npc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_isa_pkg::*;
	import npc_pkg::*;

	localparam int n_tests = 3;
	localparam int mem_words = 256;
	localparam int max_exp = 512;
	localparam logic [31:0] mem_bytes = 32'h400;

	logic        clk, rst;
	logic        arvalid, arready, rvalid, rready;
	logic [31:0] araddr, rdata;
	logic [1:0]  rresp;
	logic        commit_valid, commit_we, halt, bus_error;
	logic [31:0] commit_pc, commit_wdata;
	logic [4:0]  commit_rd;

	npc_top uut (.*);

	integer seed = 32'hadd4_078c;
	logic [31:0] progs [n_tests][mem_words];
	logic [31:0] mem [mem_words];
	logic [31:0] exp_pc [max_exp];
	logic [4:0]  exp_rd [max_exp];
	logic        exp_we [max_exp];
	logic [31:0] exp_wdata [max_exp];
	logic        exp_berr;
	int          n_exp, idx, errors, passed, cycles, limit, total, put_k;
	string       names [n_tests] = '{"alu", "control", "bus_error"};

	// memory responder state
	logic        ar_hs, r_hs, pending;
	logic [31:0] hs_addr;
	int          delay;

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// instruction encoders
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_r};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		rv_inst_u w;
		w.b.imm12   = off[12];
		w.b.imm10_5 = off[10:5];
		w.b.rs2     = rs2;
		w.b.rs1     = rs1;
		w.b.funct3  = f3;
		w.b.imm4_1  = off[4:1];
		w.b.imm11   = off[11];
		w.b.opcode  = op_b;
		return w;
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		rv_inst_u w;
		w.j.imm20    = off[20];
		w.j.imm10_1  = off[10:1];
		w.j.imm11    = off[11];
		w.j.imm19_12 = off[19:12];
		w.j.rd       = rd;
		w.j.opcode   = op_j;
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// walks program t and fills the expected commit table
	task automatic predict(input int t);
		logic [31:0] x [32];
		logic [31:0] pc, in, a, b, res, nxt, imm_i, imm_b, imm_u, imm_j;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic        alt, we;
		x = '{default: '0};
		n_exp = 0;
		exp_berr = 1'b0;
		pc = reset_pc;
		while (n_exp < max_exp) begin
			if ((pc - reset_pc) >= mem_bytes) begin
				exp_berr = 1'b1;
				break;
			end
			in = progs[t][int'((pc - reset_pc) >> 2)];
			rd = in[11:7];
			f3 = in[14:12];
			alt = (in[31:25] == f7_alt);
			a = x[in[19:15]];
			b = x[in[24:20]];
			imm_i = {{20{in[31]}}, in[31:20]};
			imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
			imm_u = {in[31:12], 12'b0};
			imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
			we = 1'b1;
			res = '0;
			nxt = pc + 32'd4;
			case (in[6:0])
				op_r: res = compute_alu(f3, alt, a, b);
				op_i: res = compute_alu(f3, alt && f3 == f3_sr, a, imm_i);
				op_u: res = imm_u;
				op_upc: res = pc + imm_u;
				op_j: begin
					res = pc + 32'd4;
					nxt = pc + imm_j;
				end
				op_jr: begin
					res = pc + 32'd4;
					nxt = (a + imm_i) & ~32'd1;
				end
				op_b: begin
					we = 1'b0;
					if (branch_taken(f3, a, b))
						nxt = pc + imm_b;
				end
				default: we = 1'b0;
			endcase
			exp_pc[n_exp] = pc;
			exp_rd[n_exp] = rd;
			exp_we[n_exp] = we;
			exp_wdata[n_exp] = res;
			n_exp++;
			if (we && rd != 5'd0)
				x[rd] = res;
			if (in == inst_ebreak)
				break;
			pc = nxt;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// programs
	////////////////////////////////////////////////////////////////////////////

	task automatic put(input int t, input logic [31:0] w);
		progs[t][put_k] = w;
		put_k++;
	endtask

	// unused words hold addi x0, x0, word index
	task automatic fill(input int t);
		for (int k = 0; k < mem_words; k++)
			progs[t][k] = enc_i(k[11:0], 5'd0, f3_add, 5'd0, op_i);
		put_k = 0;
	endtask

	task automatic build_alu();
		logic [31:0] r;
		logic [11:0] imm;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic        alt;
		fill(0);
		// kind, funct3 and alternate bit swept from k, operands random
		for (int k = 0; k < 60; k++) begin
			r = $random(seed);
			f3 = k[4:2];
			alt = k[5];
			imm = r[31:20];
			f7 = (alt && (f3 == f3_add || f3 == f3_sr)) ? f7_alt : 7'd0;
			if (f3 == f3_sll)
				imm = {7'd0, r[24:20]};
			else if (f3 == f3_sr)
				imm = {alt ? f7_alt : 7'd0, r[25:21]};
			// some writes land in x0, some reads come from it
			rd = (k % 8 == 4 || k % 8 == 5) ? 5'd0 : r[6:2];
			rs1 = (k % 16 == 9) ? 5'd0 : r[11:7];
			case (k[1:0])
				2'd0: put(0, enc_r(f7, r[16:12], rs1, f3, rd));
				2'd1: put(0, enc_i(imm, rs1, f3, rd, op_i));
				2'd2: put(0, enc_u(r[31:12], r[6:2], op_u));
				default: put(0, enc_u(r[31:12], r[6:2], op_upc));
			endcase
		end
		put(0, inst_ebreak);
	endtask

	task automatic build_control();
		logic [2:0] brs [6];
		logic [4:0] ra [4];
		logic [4:0] rb [4];
		brs = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
		ra = '{5'd1, 5'd1, 5'd2, 5'd1};
		rb = '{5'd3, 5'd2, 5'd1, 5'd4};
		fill(1);
		put(1, enc_i(12'd5, 5'd0, f3_add, 5'd1, op_i));
		put(1, enc_i(12'hffd, 5'd0, f3_add, 5'd2, op_i));
		put(1, enc_i(12'd5, 5'd0, f3_add, 5'd3, op_i));
		put(1, enc_i(12'd7, 5'd0, f3_add, 5'd4, op_i));
		// each branch skips one addi when taken
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 4; j++) begin
				put(1, enc_b(13'd8, rb[j], ra[j], brs[i]));
				put(1, enc_i(12'd1, 5'd10, f3_add, 5'd10, op_i));
			end
		end
		// short backward loop
		put(1, enc_i(12'd3, 5'd0, f3_add, 5'd8, op_i));
		put(1, enc_i(12'hfff, 5'd8, f3_add, 5'd8, op_i));
		put(1, enc_b(13'h1ffc, 5'd0, 5'd8, f3_bne));
		put(1, enc_j(21'd8, 5'd5));
		put(1, enc_i(12'd100, 5'd10, f3_add, 5'd10, op_i));
		// jalr to an odd address, bit 0 dropped
		put(1, enc_u(20'd0, 5'd6, op_upc));
		put(1, enc_i(12'd17, 5'd6, f3_add, 5'd6, op_i));
		put(1, enc_i(12'd0, 5'd6, f3_add, 5'd7, op_jr));
		put(1, enc_i(12'd7, 5'd10, f3_add, 5'd10, op_i));
		put(1, inst_ebreak);
	endtask

	task automatic build_bus_error();
		fill(2);
		put(2, enc_i(12'd1, 5'd0, f3_add, 5'd1, op_i));
		put(2, enc_u(20'h80001, 5'd9, op_u));
		put(2, enc_i(12'd0, 5'd9, f3_add, 5'd0, op_jr));
		put(2, inst_ebreak);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite read responder
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		ar_hs <= arvalid && arready;
		r_hs  <= rvalid && rready;
		if (arvalid && arready)
			hs_addr <= araddr;
	end

	always @(negedge clk) begin : responder
		logic [31:0] r;
		r = $random(seed);
		if (rst) begin
			arready = 1'b0;
			rvalid  = 1'b0;
			pending = 1'b0;
		end else begin
			arready = r[0];
			if (r_hs)
				rvalid = 1'b0;
			if (ar_hs) begin
				pending = 1'b1;
				delay   = int'(r[2:1]);
			end
			if (pending && !rvalid) begin
				if (delay == 0) begin
					rvalid  = 1'b1;
					pending = 1'b0;
					if ((hs_addr - reset_pc) < mem_bytes) begin
						rdata = mem[int'((hs_addr - reset_pc) >> 2)];
						rresp = axi_okay;
					end else begin
						rdata = '0;
						rresp = 2'b10;
					end
				end else begin
					delay--;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// commit checks
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst)
			idx <= 0;
		else if (commit_valid)
			idx <= idx + 1;
	end

	a_count: assert property (@(posedge clk) disable iff (rst) commit_valid |-> idx < n_exp)
		else begin
			$display("unexpected commit at %0t, only %0d expected", $time, n_exp);
			errors++;
		end

	a_pc: assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> commit_pc == exp_pc[idx])
		else begin
			$display("ERR %0t commit_pc expected %h got %h", $time,
				$sampled(exp_pc[idx]), $sampled(commit_pc));
			errors++;
		end

	a_rd: assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> commit_rd == exp_rd[idx])
		else begin
			$display("ERR %0t commit_rd expected %0d got %0d", $time,
				$sampled(exp_rd[idx]), $sampled(commit_rd));
			errors++;
		end

	a_we: assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> commit_we == exp_we[idx])
		else begin
			$display("ERR %0t commit_we expected %b got %b", $time,
				$sampled(exp_we[idx]), $sampled(commit_we));
			errors++;
		end

	a_wdata: assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> commit_wdata == exp_wdata[idx])
		else begin
			$display("ERR %0t commit_wdata expected %h got %h", $time,
				$sampled(exp_wdata[idx]), $sampled(commit_wdata));
			errors++;
		end

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: core did not halt within %0d cycles", limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic run_test(input int t);
		int start;
		start = errors;
		for (int k = 0; k < mem_words; k++)
			mem[k] = progs[t][k];
		predict(t);
		@(negedge clk);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		while (!halt)
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (idx == n_exp)
			else begin
				$display("%s: %0d commits seen, %0d expected", names[t], idx, n_exp);
				errors++;
			end
		assert (bus_error == exp_berr)
			else begin
				$display("ERR %0t bus_error expected %b got %b", $time, exp_berr, bus_error);
				errors++;
			end
		if (errors == start)
			passed++;
		$display("test %s done: %0d commits, %0d errors", names[t], n_exp, errors - start);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = axi_okay;
		pending = 1'b0;
		delay = 0;
		errors = 0;
		passed = 0;
		cycles = 0;
		limit = 0;
		build_alu();
		build_control();
		build_bus_error();
		total = 0;
		for (int t = 0; t < n_tests; t++) begin
			predict(t);
			total += n_exp;
		end
		// worst case fetch is 6 cycles per instruction
		limit = 8 * total * 6 + 100;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("tests: %0d run, %0d passed, %0d errors", n_tests, passed, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: project.f
rtl/rv_isa_pkg.sv
rtl/npc_pkg.sv
rtl/npc_fetch.sv
rtl/npc_decode.sv
rtl/npc_regfile.sv
rtl/npc_execute.sv
rtl/npc_result.sv
rtl/npc_top.sv
bench/npc_sva.sv
bench/npc_tb.sv

// File: rtl/npc_decode.sv
module npc_decode (
	input  logic [31:0]        inst,
	output logic [4:0]         rs1,
	output logic [4:0]         rs2,
	output logic [4:0]         rd,
	output logic [31:0]        imm,
	output npc_pkg::alu_op_t   alu_op,
	output logic               use_imm,
	output logic               use_pc,
	output logic               is_branch,
	output logic               is_jal,
	output logic               is_jalr,
	output logic [2:0]         br_f3,
	output npc_pkg::res_sel_t  res_sel,
	output logic               is_ebreak,
	output logic               illegal
);
	import rv_isa_pkg::*;
	import npc_pkg::*;

	rv_inst_u w;
	logic     alt;
	logic [31:0] imm_i, imm_b, imm_u, imm_j;

	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt_f7,
			input logic sub_en);
		case (f3)
			f3_add:  return (sub_en && alt_f7) ? alu_sub : alu_add;
			f3_sll:  return alu_sll;
			f3_slt:  return alu_slt;
			f3_sltu: return alu_sltu;
			f3_xor:  return alu_xor;
			f3_sr:   return alt_f7 ? alu_sra : alu_srl;
			f3_or:   return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign w     = inst;
	assign rs1   = w.r.rs1;
	assign rs2   = w.s.rs2;
	assign rd    = w.r.rd;
	assign br_f3 = w.b.funct3;
	assign alt   = (w.r.funct7 == f7_alt);

	////////////////////////////////////////////////////////////////////////////
	// immediates
	////////////////////////////////////////////////////////////////////////////

	assign imm_i = {{20{w.i.imm[11]}}, w.i.imm};
	assign imm_b = {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
	assign imm_u = {w.u.imm, 12'b0};
	assign imm_j = {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		imm       = '0;
		alu_op    = alu_add;
		use_imm   = 1'b0;
		use_pc    = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		res_sel   = res_none;
		is_ebreak = 1'b0;
		illegal   = 1'b0;
		case (w.r.opcode)
			op_r: begin
				alu_op  = arith_op(w.r.funct3, alt, 1'b1);
				res_sel = res_alu;
			end
			op_i: begin
				// funct7 only matters for srai here
				imm     = imm_i;
				use_imm = 1'b1;
				alu_op  = arith_op(w.i.funct3, alt, 1'b0);
				res_sel = res_alu;
			end
			op_u: begin
				imm     = imm_u;
				use_imm = 1'b1;
				alu_op  = alu_copy_b;
				res_sel = res_alu;
			end
			op_upc: begin
				imm     = imm_u;
				use_imm = 1'b1;
				use_pc  = 1'b1;
				res_sel = res_alu;
			end
			op_b: begin
				imm       = imm_b;
				is_branch = 1'b1;
				// 010 and 011 are not branches
				illegal   = (w.b.funct3 == 3'b010) || (w.b.funct3 == 3'b011);
			end
			op_j: begin
				imm     = imm_j;
				is_jal  = 1'b1;
				res_sel = res_link;
			end
			op_jr: begin
				imm     = imm_i;
				use_imm = 1'b1;
				is_jalr = 1'b1;
				res_sel = res_link;
			end
			op_sys: begin
				is_ebreak = (inst == inst_ebreak);
				illegal   = (inst != inst_ebreak);
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

// File: rtl/npc_execute.sv
module npc_execute (
	input  logic [31:0]       rdata1,
	input  logic [31:0]       rdata2,
	input  logic [31:0]       pc,
	input  logic [31:0]       imm,
	input  npc_pkg::alu_op_t  alu_op,
	input  logic              use_imm,
	input  logic              use_pc,
	input  logic [2:0]        br_f3,
	output logic [31:0]       alu_out,
	output logic              br_taken
);
	import rv_isa_pkg::*;
	import npc_pkg::*;

	logic [31:0] a, b;
	logic [4:0]  shamt;

	assign a     = use_pc ? pc : rdata1;
	assign b     = use_imm ? imm : rdata2;
	assign shamt = b[4:0];

	always_comb begin
		case (alu_op)
			alu_add:    alu_out = a + b;
			alu_sub:    alu_out = a - b;
			alu_sll:    alu_out = a << shamt;
			alu_slt:    alu_out = {31'b0, $signed(a) < $signed(b)};
			alu_sltu:   alu_out = {31'b0, a < b};
			alu_xor:    alu_out = a ^ b;
			alu_srl:    alu_out = a >> shamt;
			alu_sra:    alu_out = $unsigned($signed(a) >>> shamt);
			alu_or:     alu_out = a | b;
			alu_and:    alu_out = a & b;
			alu_copy_b: alu_out = b;
			default:    alu_out = '0;
		endcase
	end

	// branch compare always on the two register values
	always_comb begin
		case (br_f3)
			f3_beq:  br_taken = (rdata1 == rdata2);
			f3_bne:  br_taken = (rdata1 != rdata2);
			f3_blt:  br_taken = $signed(rdata1) < $signed(rdata2);
			f3_bge:  br_taken = $signed(rdata1) >= $signed(rdata2);
			f3_bltu: br_taken = rdata1 < rdata2;
			f3_bgeu: br_taken = rdata1 >= rdata2;
			default: br_taken = 1'b0;
		endcase
	end

endmodule

// File: rtl/npc_fetch.sv
module npc_fetch (
	input  logic        clk,
	input  logic        rst,
	output logic        arvalid,
	output logic [31:0] araddr,
	input  logic        arready,
	input  logic        rvalid,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	output logic        rready,
	input  logic [31:0] next_pc,
	input  logic        advance,
	output logic [31:0] inst,
	output logic        inst_valid,
	output logic [31:0] pc,
	output logic        bus_error
);
	import npc_pkg::*;

	localparam logic [1:0] st_req  = 2'd0;
	localparam logic [1:0] st_data = 2'd1;
	localparam logic [1:0] st_exec = 2'd2;

	logic [1:0] state;
	// set on halt or bad response, never cleared
	logic       stopped;

	assign araddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_req;
			pc         <= reset_pc;
			arvalid    <= 1'b0;
			rready     <= 1'b0;
			inst_valid <= 1'b0;
			bus_error  <= 1'b0;
			stopped    <= 1'b0;
		end else begin
			case (state)
				st_req: begin
					if (arvalid && arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= st_data;
					end else if (!arvalid && !stopped) begin
						// first request out of reset
						arvalid <= 1'b1;
					end
				end
				st_data: begin
					if (rvalid) begin
						rready <= 1'b0;
						if (rresp == axi_okay) begin
							inst_valid <= 1'b1;
							state      <= st_exec;
						end else begin
							bus_error <= 1'b1;
							stopped   <= 1'b1;
							state     <= st_req;
						end
					end
				end
				default: begin
					inst_valid <= 1'b0;
					state      <= st_req;
					if (advance) begin
						pc      <= next_pc;
						arvalid <= 1'b1;
					end else begin
						stopped <= 1'b1;
					end
				end
			endcase
		end
	end

	// instruction register, loaded on a good data beat
	always_ff @(posedge clk) begin
		if (state == st_data && rvalid && rresp == axi_okay)
			inst <= rdata;
	end

endmodule

// File: rtl/npc_pkg.sv
package npc_pkg;

	localparam logic [31:0] reset_pc = 32'h8000_0000;
	localparam int xlen   = 32;
	localparam int reg_aw = 5;

	// AXI response
	localparam logic [1:0] axi_okay = 2'b00;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_copy_b
	} alu_op_t;

	// where the written value comes from
	typedef enum logic [1:0] {
		res_alu,
		res_link,
		res_none
	} res_sel_t;

endpackage

// File: rtl/npc_regfile.sv
module npc_regfile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);
	import npc_pkg::*;

	// x0 has no storage
	logic [xlen-1:0] regs [1:(1 << reg_aw) - 1];

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < (1 << reg_aw); i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// File: rtl/npc_result.sv
module npc_result (
	input  logic              clk,
	input  logic              rst,
	input  logic              inst_valid,
	input  logic [31:0]       pc,
	input  logic [31:0]       imm,
	input  logic [31:0]       alu_out,
	input  logic              br_taken,
	input  logic              is_branch,
	input  logic              is_jal,
	input  logic              is_jalr,
	input  logic [4:0]        rd,
	input  npc_pkg::res_sel_t res_sel,
	input  logic              is_ebreak,
	input  logic              illegal,
	input  logic              bus_error,
	output logic [31:0]       next_pc,
	output logic              advance,
	output logic              we,
	output logic [4:0]        waddr,
	output logic [31:0]       wdata,
	output logic              commit_valid,
	output logic [31:0]       commit_pc,
	output logic [4:0]        commit_rd,
	output logic [31:0]       commit_wdata,
	output logic              commit_we,
	output logic              halt
);
	import npc_pkg::*;

	logic [31:0] pc_seq;
	logic        stop_now;
	logic        halt_q;

	assign pc_seq   = pc + 32'd4;
	assign stop_now = is_ebreak || illegal;
	assign advance  = inst_valid && !stop_now;

	always_comb begin
		if (is_jalr)
			next_pc = {alu_out[31:1], 1'b0};
		else if (is_jal || (is_branch && br_taken))
			next_pc = pc + imm;
		else
			next_pc = pc_seq;
	end

	// register write port
	assign we    = inst_valid && (res_sel != res_none);
	assign waddr = rd;
	assign wdata = (res_sel == res_link) ? pc_seq : alu_out;

	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid <= 1'b0;
			commit_pc    <= reset_pc;
			commit_rd    <= '0;
			commit_wdata <= '0;
			commit_we    <= 1'b0;
			halt_q       <= 1'b0;
		end else begin
			commit_valid <= inst_valid;
			if (inst_valid) begin
				commit_pc    <= pc;
				commit_rd    <= rd;
				commit_wdata <= we ? wdata : '0;
				commit_we    <= we;
				if (stop_now)
					halt_q <= 1'b1;
			end
		end
	end

	// a bad fetch halts in the same cycle it is flagged
	assign halt = halt_q || bus_error;

endmodule

// File: rtl/npc_top.sv
module npc_top (
	input  logic        clk,
	input  logic        rst,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	output logic        commit_valid,
	output logic [31:0] commit_pc,
	output logic [4:0]  commit_rd,
	output logic [31:0] commit_wdata,
	output logic        commit_we,
	output logic        halt,
	output logic        bus_error
);
	import npc_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal wires
	////////////////////////////////////////////////////////////////////////////

	logic [31:0] inst, pc, next_pc, imm;
	logic        inst_valid, advance;
	logic [4:0]  rs1, rs2, rd;
	alu_op_t     alu_op;
	res_sel_t    res_sel;
	logic        use_imm, use_pc, is_branch, is_jal, is_jalr;
	logic [2:0]  br_f3;
	logic        is_ebreak, illegal;
	logic [31:0] rdata1, rdata2, alu_out;
	logic        br_taken;
	logic        we;
	logic [4:0]  waddr;
	logic [31:0] wdata;

	npc_fetch u_fetch (
		.clk(clk), .rst(rst),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.next_pc(next_pc), .advance(advance),
		.inst(inst), .inst_valid(inst_valid), .pc(pc), .bus_error(bus_error)
	);

	npc_decode u_decode (
		.inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
		.use_imm(use_imm), .use_pc(use_pc),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .br_f3(br_f3),
		.res_sel(res_sel), .is_ebreak(is_ebreak), .illegal(illegal)
	);

	npc_regfile u_regfile (
		.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
		.we(we), .waddr(waddr), .wdata(wdata)
	);

	npc_execute u_execute (
		.rdata1(rdata1), .rdata2(rdata2), .pc(pc), .imm(imm), .alu_op(alu_op),
		.use_imm(use_imm), .use_pc(use_pc), .br_f3(br_f3),
		.alu_out(alu_out), .br_taken(br_taken)
	);

	npc_result u_result (
		.clk(clk), .rst(rst), .inst_valid(inst_valid), .pc(pc), .imm(imm),
		.alu_out(alu_out), .br_taken(br_taken),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
		.rd(rd), .res_sel(res_sel), .is_ebreak(is_ebreak), .illegal(illegal),
		.bus_error(bus_error), .next_pc(next_pc), .advance(advance),
		.we(we), .waddr(waddr), .wdata(wdata),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
		.commit_wdata(commit_wdata), .commit_we(commit_we), .halt(halt)
	);

endmodule

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [6:0] op_r   = 7'b0110011;
	localparam logic [6:0] op_i   = 7'b0010011;
	localparam logic [6:0] op_u   = 7'b0110111;
	localparam logic [6:0] op_upc = 7'b0010111;
	localparam logic [6:0] op_b   = 7'b1100011;
	localparam logic [6:0] op_j   = 7'b1101111;
	localparam logic [6:0] op_jr  = 7'b1100111;
	localparam logic [6:0] op_sys = 7'b1110011;

	// arithmetic funct3
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// branch funct3
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// sub / sra
	localparam logic [6:0] f7_alt = 7'b0100000;

	localparam logic [31:0] inst_ebreak = 32'h0010_0073;

	////////////////////////////////////////////////////////////////////////////
	// instruction word layouts
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} rv_s_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} rv_b_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_u_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_j_t;

	typedef union packed {
		rv_r_t r;
		rv_i_t i;
		rv_s_t s;
		rv_b_t b;
		rv_u_t u;
		rv_j_t j;
	} rv_inst_u;

endpackage

// File: run.sh
#!/bin/bash
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
	--top-module npc_tb --Mdir obj_dir -o npc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/npc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
